//--- hw/pipeDefsPkg.sv
// Data path and data memory sizing; DMEM_WORDS must stay a power of two for the index width
`default_nettype none

package pipeDefsPkg;

    // ------------------------------
    // Data path
    // ------------------------------

    // Width of the data path and of one memory word
    localparam int DATA_W = 32;

    // Register file destination address
    localparam int RADDR_W = 5;

    // Byte address carried to the data memory
    // Taken from the low bits of the ALU result
    localparam int MADDR_W = 16;

    // ------------------------------
    // Data memory
    // ------------------------------

    // Depth in 32-bit words
    localparam int DMEM_WORDS = 1024;

    // Word index width, taken from address bits 11:2
    // Bits above the index are ignored by the memory
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

endpackage

`default_nettype wire

//--- hw/memOpPkg.sv
// Memory function codes and the word view used for lane selection; code 7 acts as a word access
`default_nettype none

package memOpPkg;

    // ------------------------------
    // Function codes
    // ------------------------------

    localparam int MEMFUNC_W = 3;

    // Byte access, sign extended on load
    // Also the code for a byte store
    localparam logic [MEMFUNC_W-1:0] MF_BS = 3'd0;
    // Byte load, zero extended
    localparam logic [MEMFUNC_W-1:0] MF_BU = 3'd1;
    // Halfword access, sign extended on load
    // Also the code for a halfword store
    localparam logic [MEMFUNC_W-1:0] MF_HS = 3'd2;
    // Halfword load, zero extended
    localparam logic [MEMFUNC_W-1:0] MF_HU = 3'd3;
    // Full word
    localparam logic [MEMFUNC_W-1:0] MF_WD = 3'd4;
    // Upper half from memory, lower half from the register operand
    localparam logic [MEMFUNC_W-1:0] MF_WL = 3'd5;
    // Upper half from the register operand, lower half from memory
    localparam logic [MEMFUNC_W-1:0] MF_WR = 3'd6;

    // ------------------------------
    // Memory word view
    // ------------------------------

    // One 32-bit word, split into byte lanes or half lanes
    // Lane 0 is the least significant in both views
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } memWordT;

endpackage

`default_nettype wire

//--- hw/exMemReg.sv
// Execute/memory register with no stall input; only the strobes are reset, data fields start undefined
`default_nettype none
`timescale 1ns/10ps

module exMemReg
    import pipeDefsPkg::*;
    import memOpPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 arstN,
    // Execute stage results
    input  wire logic                 regWriteIn,
    input  wire logic                 memToRegIn,
    input  wire logic                 memReadIn,
    input  wire logic                 memWriteIn,
    input  wire logic [RADDR_W-1:0]   rAddrIn,
    input  wire logic [MEMFUNC_W-1:0] memFunc,
    input  wire logic [DATA_W-1:0]    rtData,
    input  wire logic [DATA_W-1:0]    aluData,
    // Registered towards the memory stage
    output logic                      regWrite,
    output logic                      memToReg,
    output logic                      memRead,
    output logic                      memWrite,
    output logic [RADDR_W-1:0]        rAddr,
    output logic [MEMFUNC_W-1:0]      memFuncQ,
    output logic [DATA_W-1:0]         rtDataQ,
    output logic [DATA_W-1:0]         aluDataQ
);

    // ------------------------------
    // Control strobes
    // ------------------------------

    // Cleared on reset so no write or writeback fires from an empty slot
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            regWrite <= 1'b0;
            memToReg <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
        end
        else
        begin
            regWrite <= regWriteIn;
            memToReg <= memToRegIn;
            memRead  <= memReadIn;
            memWrite <= memWriteIn;
        end
    end

    // ------------------------------
    // Data fields
    // ------------------------------

    // Free running, meaningful only when a strobe qualifies them
    always_ff @(posedge clk)
    begin
        rAddr    <= rAddrIn;
        memFuncQ <= memFunc;
        // Store operand, also the merge source for WL and WR
        rtDataQ  <= rtData;
        // ALU result, its low bits are the memory byte address
        aluDataQ <= aluData;
    end

endmodule

`default_nettype wire

//--- hw/memStage.sv
// Load and store lane formatting; no misalignment trap, a halfword access must have address bit 0 low
`default_nettype none
`timescale 1ns/10ps

module memStage
    import pipeDefsPkg::*;
    import memOpPkg::*;
(
    // From the execute/memory register
    input  wire logic                 regWrite,
    input  wire logic                 memToReg,
    input  wire logic                 memRead,
    input  wire logic                 memWrite,
    input  wire logic [RADDR_W-1:0]   rAddr,
    input  wire logic [MEMFUNC_W-1:0] memFunc,
    input  wire logic [DATA_W-1:0]    rtData,
    input  wire logic [DATA_W-1:0]    aluData,
    // Combinational read data from the data memory
    input  wire logic [DATA_W-1:0]    memReadData,
    // To the data memory
    output logic [MADDR_W-1:0]        memAddr,
    output logic                      memWriteEn,
    output logic [DATA_W/8-1:0]       byteEn,
    output logic [DATA_W-1:0]         memWriteData,
    // To the memory/writeback register
    output logic                      regWriteOut,
    output logic                      memToRegOut,
    output logic [RADDR_W-1:0]        rAddrOut,
    output logic [DATA_W-1:0]         loadData,
    output logic [DATA_W-1:0]         aluDataOut
);

    memWordT    rdWord;
    memWordT    wrWord;
    logic [7:0]  rdByte;
    logic [15:0] rdHalf;

    // Byte address is the low part of the ALU result
    assign memAddr    = aluData[MADDR_W-1:0];
    assign memWriteEn = memWrite;

    // ------------------------------
    // Load path
    // ------------------------------

    assign rdWord = memReadData;
    // Lane picked by the low address bits
    assign rdByte = rdWord.bytes[memAddr[1:0]];
    assign rdHalf = rdWord.halves[memAddr[1]];

    always_comb
    begin
        case (memFunc)
            MF_BS:   loadData = {{(DATA_W-8){rdByte[7]}}, rdByte};
            MF_BU:   loadData = {{(DATA_W-8){1'b0}}, rdByte};
            MF_HS:   loadData = {{(DATA_W-16){rdHalf[15]}}, rdHalf};
            MF_HU:   loadData = {{(DATA_W-16){1'b0}}, rdHalf};
            // Merges always use the fixed halves, not the addressed lane
            MF_WL:   loadData = {rdWord.halves[1], rtData[15:0]};
            MF_WR:   loadData = {rtData[31:16], rdWord.halves[0]};
            // MF_WD and the spare code
            default: loadData = memReadData;
        endcase
    end

    // ------------------------------
    // Store path
    // ------------------------------

    // Narrow data is copied into every lane, byteEn picks the one written
    always_comb
    begin
        case (memFunc)
            MF_BS:
            begin
                wrWord.bytes = {4{rtData[7:0]}};
                byteEn       = 4'b0001 << memAddr[1:0];
            end
            MF_HS:
            begin
                wrWord.halves = {2{rtData[15:0]}};
                byteEn        = memAddr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                // Every other code stores the whole operand
                wrWord = rtData;
                byteEn = 4'b1111;
            end
        endcase
    end

    assign memWriteData = wrWord;

    // Writeback controls and ALU result pass on to the next register
    assign regWriteOut = regWrite;
    assign memToRegOut = memToReg;
    assign rAddrOut    = rAddr;
    assign aluDataOut  = aluData;

    // ------------------------------
    // Checks
    // ------------------------------

    // Decoder upstream must never issue a load and a store in one slot
    always_comb
    begin
        assert final (!(memRead && memWrite))
            else $error("memStage: memRead and memWrite both high");
    end

    // Half lanes are only defined on even byte addresses
    always_comb
    begin
        assert final (!((memRead || memWrite) &&
                        (memFunc == MF_HS || memFunc == MF_HU) && memAddr[0]))
            else $error("memStage: odd address on halfword access");
    end

endmodule

`default_nettype wire

//--- hw/dataMem.sv
// Word memory without reset, read asynchronous, write on the edge; address bits above 11 are ignored
`default_nettype none
`timescale 1ns/10ps

module dataMem
    import pipeDefsPkg::*;
(
    input  wire logic                clk,
    // Byte address, bits 1:0 select a lane through byteEn only
    input  wire logic [MADDR_W-1:0]  addr,
    input  wire logic                writeEn,
    input  wire logic [DATA_W/8-1:0] byteEn,
    input  wire logic [DATA_W-1:0]   writeData,
    output logic [DATA_W-1:0]        readData
);

    // ------------------------------
    // Storage
    // ------------------------------

    logic [DATA_W-1:0]     mem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] wordIdx;

    // Word index sits just above the byte offset
    assign wordIdx = addr[DMEM_IDX_W+1:2];

    // Combinational read, so a load sees last edge's store
    assign readData = mem[wordIdx];

    // ------------------------------
    // Write port
    // ------------------------------

    // Only the enabled bytes change
    always_ff @(posedge clk)
    begin
        if (writeEn)
        begin
            for (int b = 0; b < DATA_W/8; b++)
            begin
                if (byteEn[b])
                begin
                    mem[wordIdx][b*8 +: 8] <= writeData[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // The memory stage must name at least one lane for every store
    assert property (@(posedge clk) writeEn |-> (byteEn != '0))
        else $error("dataMem: write with no byte enabled");

endmodule

`default_nettype wire

//--- hw/memWbReg.sv
// Memory/writeback register with no stall; wbRegWrite resets low, wbRAddr and wbData do not
`default_nettype none
`timescale 1ns/10ps

module memWbReg
    import pipeDefsPkg::*;
(
    input  wire logic               clk,
    input  wire logic               arstN,
    // From the memory stage
    input  wire logic               regWrite,
    input  wire logic               memToReg,
    input  wire logic [RADDR_W-1:0] rAddr,
    input  wire logic [DATA_W-1:0]  loadData,
    input  wire logic [DATA_W-1:0]  aluData,
    // Towards the register file write port
    output logic                    wbRegWrite,
    output logic [RADDR_W-1:0]      wbRAddr,
    output logic [DATA_W-1:0]       wbData
);

    logic [DATA_W-1:0] wbDataNext;

    // ------------------------------
    // Writeback select
    // ------------------------------

    // Loads return memory data, everything else the ALU result
    assign wbDataNext = memToReg ? loadData : aluData;

    // ------------------------------
    // Registers
    // ------------------------------

    // Write strobe is the only control here
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wbRegWrite <= 1'b0;
        end
        else
        begin
            wbRegWrite <= regWrite;
        end
    end

    // Destination and value follow the strobe
    always_ff @(posedge clk)
    begin
        wbRAddr <= rAddr;
        wbData  <= wbDataNext;
    end

endmodule

`default_nettype wire

//--- hw/memSubsys.sv
// Memory section top; two-edge latency, one op per cycle, no stalls, hazards or forwarding
`default_nettype none
`timescale 1ns/10ps

module memSubsys
    import pipeDefsPkg::*;
    import memOpPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 arstN,
    // Execute stage results
    input  wire logic                 regWriteIn,
    input  wire logic                 memToRegIn,
    input  wire logic                 memReadIn,
    input  wire logic                 memWriteIn,
    input  wire logic [RADDR_W-1:0]   rAddrIn,
    input  wire logic [MEMFUNC_W-1:0] memFunc,
    input  wire logic [DATA_W-1:0]    rtData,
    input  wire logic [DATA_W-1:0]    aluData,
    // Writeback
    output logic                      wbRegWrite,
    output logic [RADDR_W-1:0]        wbRAddr,
    output logic [DATA_W-1:0]         wbData
);

    // ------------------------------
    // Execute/memory register outputs
    // ------------------------------

    logic                 exRegWrite;
    logic                 exMemToReg;
    logic                 exMemRead;
    logic                 exMemWrite;
    logic [RADDR_W-1:0]   exRAddr;
    logic [MEMFUNC_W-1:0] exMemFunc;
    logic [DATA_W-1:0]    exRtData;
    logic [DATA_W-1:0]    exAluData;

    // Memory port
    logic [MADDR_W-1:0]   memAddr;
    logic                 memWriteEn;
    logic [DATA_W/8-1:0]  byteEn;
    logic [DATA_W-1:0]    memWriteData;
    logic [DATA_W-1:0]    memReadData;

    // Memory stage towards writeback
    logic                 msRegWrite;
    logic                 msMemToReg;
    logic [RADDR_W-1:0]   msRAddr;
    logic [DATA_W-1:0]    msLoadData;
    logic [DATA_W-1:0]    msAluData;

    exMemReg uExMemReg (
        .clk        (clk),
        .arstN      (arstN),
        .regWriteIn (regWriteIn),
        .memToRegIn (memToRegIn),
        .memReadIn  (memReadIn),
        .memWriteIn (memWriteIn),
        .rAddrIn    (rAddrIn),
        .memFunc    (memFunc),
        .rtData     (rtData),
        .aluData    (aluData),
        .regWrite   (exRegWrite),
        .memToReg   (exMemToReg),
        .memRead    (exMemRead),
        .memWrite   (exMemWrite),
        .rAddr      (exRAddr),
        .memFuncQ   (exMemFunc),
        .rtDataQ    (exRtData),
        .aluDataQ   (exAluData)
    );

    memStage uMemStage (
        .regWrite     (exRegWrite),
        .memToReg     (exMemToReg),
        .memRead      (exMemRead),
        .memWrite     (exMemWrite),
        .rAddr        (exRAddr),
        .memFunc      (exMemFunc),
        .rtData       (exRtData),
        .aluData      (exAluData),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteEn   (memWriteEn),
        .byteEn       (byteEn),
        .memWriteData (memWriteData),
        .regWriteOut  (msRegWrite),
        .memToRegOut  (msMemToReg),
        .rAddrOut     (msRAddr),
        .loadData     (msLoadData),
        .aluDataOut   (msAluData)
    );

    dataMem uDataMem (
        .clk       (clk),
        .addr      (memAddr),
        .writeEn   (memWriteEn),
        .byteEn    (byteEn),
        .writeData (memWriteData),
        .readData  (memReadData)
    );

    memWbReg uMemWbReg (
        .clk        (clk),
        .arstN      (arstN),
        .regWrite   (msRegWrite),
        .memToReg   (msMemToReg),
        .rAddr      (msRAddr),
        .loadData   (msLoadData),
        .aluData    (msAluData),
        .wbRegWrite (wbRegWrite),
        .wbRAddr    (wbRAddr),
        .wbData     (wbData)
    );

endmodule

`default_nettype wire

//--- tests/memSubsysTb.sv
// Row checked two edges after drive; memory has no reset, so loads only read stored words
`default_nettype none
`timescale 1ns/10ps

module memSubsysTb
    import pipeDefsPkg::*;
    import memOpPkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam logic [31:0] SEED = 32'he494a192;

    // Row controls as {regWrite, memToReg, memRead, memWrite}
    localparam logic [3:0] CTL_IDLE  = 4'b0000;
    localparam logic [3:0] CTL_ALU   = 4'b1000;
    localparam logic [3:0] CTL_LOAD  = 4'b1110;
    localparam logic [3:0] CTL_STORE = 4'b0001;

    // Word with a different sign bit in every byte and half
    localparam logic [DATA_W-1:0]     KNOWN_WORD = 32'h7E81_F03C;
    localparam logic [DMEM_IDX_W-1:0] KNOWN_IDX  = 10'h155;
    localparam logic [DMEM_IDX_W-1:0] STORE_IDX  = 10'h2AA;

    logic                 clk = 1'b0;
    logic                 arstN;
    logic                 regWriteIn;
    logic                 memToRegIn;
    logic                 memReadIn;
    logic                 memWriteIn;
    logic [RADDR_W-1:0]   rAddrIn;
    logic [MEMFUNC_W-1:0] memFunc;
    logic [DATA_W-1:0]    rtData;
    logic [DATA_W-1:0]    aluData;
    logic                 wbRegWrite;
    logic [RADDR_W-1:0]   wbRAddr;
    logic [DATA_W-1:0]    wbData;

    // ------------------------------
    // Stimulus table
    // ------------------------------

    logic [3:0]           rowCtl[$];
    logic [MEMFUNC_W-1:0] rowFunc[$];
    logic [RADDR_W-1:0]   rowRAddr[$];
    logic [DATA_W-1:0]    rowRt[$];
    logic [DATA_W-1:0]    rowAlu[$];
    logic [DATA_W-1:0]    rowExp[$];
    int                   rowTest[$];
    string                testName[$];
    int                   testRows[$];
    int                   testErr[$];
    int                   curTest;
    logic                 tableReady = 1'b0;

    // Expected memory contents, updated as store rows are added
    logic [DATA_W-1:0]    shadow [DMEM_WORDS];

    memSubsys UUT (
        .clk        (clk),
        .arstN      (arstN),
        .regWriteIn (regWriteIn),
        .memToRegIn (memToRegIn),
        .memReadIn  (memReadIn),
        .memWriteIn (memWriteIn),
        .rAddrIn    (rAddrIn),
        .memFunc    (memFunc),
        .rtData     (rtData),
        .aluData    (aluData),
        .wbRegWrite (wbRegWrite),
        .wbRAddr    (wbRAddr),
        .wbData     (wbData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Random upper bits above the word index, the memory must ignore them
    function automatic logic [DATA_W-1:0] makeAddr(input logic [DMEM_IDX_W-1:0] idx,
                                                   input logic [1:0] offs);
        logic [DATA_W-1:0] r;
        r = $urandom;
        return {r[DATA_W-1:DMEM_IDX_W+2], idx, offs};
    endfunction

    // Load result from the lane rules
    function automatic logic [DATA_W-1:0] expectLoad(input logic [MEMFUNC_W-1:0] func,
                                                     input logic [DATA_W-1:0] word,
                                                     input logic [1:0] offs,
                                                     input logic [DATA_W-1:0] rt);
        memWordT     w;
        logic [7:0]  b;
        logic [15:0] h;
        w = word;
        b = 8'(word >> (8 * offs));
        h = 16'(word >> (16 * offs[1]));
        case (func)
            MF_BS:   return {{24{b[7]}}, b};
            MF_BU:   return {24'd0, b};
            MF_HS:   return {{16{h[15]}}, h};
            MF_HU:   return {16'd0, h};
            MF_WL:   return {w.halves[1], rt[15:0]};
            MF_WR:   return {rt[31:16], w.halves[0]};
            default: return word;
        endcase
    endfunction

    // Narrow stores touch one lane of the shadow word
    task automatic applyStore(input logic [MEMFUNC_W-1:0] func,
                              input logic [MADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] rt);
        memWordT w;
        w = shadow[addr[DMEM_IDX_W+1:2]];
        case (func)
            MF_BS:   w.bytes[addr[1:0]] = rt[7:0];
            MF_HS:   w.halves[addr[1]] = rt[15:0];
            default: w = rt;
        endcase
        shadow[addr[DMEM_IDX_W+1:2]] = w;
    endtask

    task automatic beginTest(input string name);
        testName.push_back(name);
        testRows.push_back(0);
        testErr.push_back(0);
        curTest = testName.size() - 1;
    endtask

    task automatic addRow(input logic [3:0] ctl, input logic [MEMFUNC_W-1:0] func,
                          input logic [RADDR_W-1:0] rAddr, input logic [DATA_W-1:0] rt,
                          input logic [DATA_W-1:0] alu);
        logic [DATA_W-1:0]  expVal;
        logic [MADDR_W-1:0] addr;
        addr = alu[MADDR_W-1:0];
        if (ctl[0])
        begin
            applyStore(func, addr, rt);
            expVal = '0;
        end
        else if (ctl[2])
            expVal = expectLoad(func, shadow[addr[DMEM_IDX_W+1:2]], addr[1:0], rt);
        else
            expVal = alu;
        rowCtl.push_back(ctl);
        rowFunc.push_back(func);
        rowRAddr.push_back(rAddr);
        rowRt.push_back(rt);
        rowAlu.push_back(alu);
        rowExp.push_back(expVal);
        rowTest.push_back(curTest);
    endtask

    // ------------------------------
    // Table contents
    // ------------------------------

    task automatic buildTable();
        logic [DATA_W-1:0]     r;
        logic [DMEM_IDX_W-1:0] wordIdx[$];
        beginTest("idle");
        repeat (3) addRow(CTL_IDLE, MF_WD, 5'd0, $urandom, $urandom);
        beginTest("alu");
        for (int i = 0; i < 6; i++)
        begin
            r = $urandom;
            addRow(CTL_ALU, MF_WD, r[RADDR_W-1:0], $urandom, $urandom);
        end
        // First store uses the spare code, which writes the whole word
        beginTest("word");
        for (int i = 0; i < 8; i++)
        begin
            r = $urandom;
            wordIdx.push_back(r[DMEM_IDX_W-1:0]);
            addRow(CTL_STORE, (i == 0) ? 3'd7 : MF_WD, 5'd0, $urandom,
                   makeAddr(r[DMEM_IDX_W-1:0], 2'd0));
        end
        for (int i = 7; i >= 0; i--)
        begin
            r = $urandom;
            addRow(CTL_LOAD, MF_WD, r[RADDR_W-1:0], $urandom, makeAddr(wordIdx[i], 2'd0));
        end
        beginTest("narrowLoad");
        addRow(CTL_STORE, MF_WD, 5'd0, KNOWN_WORD, makeAddr(KNOWN_IDX, 2'd0));
        for (int offs = 0; offs < 4; offs++)
        begin
            addRow(CTL_LOAD, MF_BS, 5'(offs + 1), $urandom, makeAddr(KNOWN_IDX, 2'(offs)));
            addRow(CTL_LOAD, MF_BU, 5'(offs + 5), $urandom, makeAddr(KNOWN_IDX, 2'(offs)));
            if (offs % 2 == 0)
            begin
                addRow(CTL_LOAD, MF_HS, 5'(offs + 9), $urandom, makeAddr(KNOWN_IDX, 2'(offs)));
                addRow(CTL_LOAD, MF_HU, 5'(offs + 13), $urandom, makeAddr(KNOWN_IDX, 2'(offs)));
            end
        end
        // Each narrow store is read back as a whole word
        beginTest("narrowStore");
        addRow(CTL_STORE, MF_WD, 5'd0, $urandom, makeAddr(STORE_IDX, 2'd0));
        for (int offs = 0; offs < 4; offs++)
        begin
            addRow(CTL_STORE, MF_BS, 5'd0, $urandom, makeAddr(STORE_IDX, 2'(offs)));
            addRow(CTL_LOAD, MF_WD, 5'd3, $urandom, makeAddr(STORE_IDX, 2'd0));
        end
        for (int offs = 0; offs < 4; offs += 2)
        begin
            addRow(CTL_STORE, MF_HS, 5'd0, $urandom, makeAddr(STORE_IDX, 2'(offs)));
            addRow(CTL_LOAD, MF_WD, 5'd4, $urandom, makeAddr(STORE_IDX, 2'd0));
        end
        beginTest("merge");
        for (int i = 0; i < 3; i++)
        begin
            r = $urandom;
            addRow(CTL_STORE, MF_WD, 5'd0, $urandom, makeAddr(r[DMEM_IDX_W-1:0], 2'd0));
            addRow(CTL_LOAD, MF_WL, 5'd7, $urandom, makeAddr(r[DMEM_IDX_W-1:0], 2'd0));
            addRow(CTL_LOAD, MF_WR, 5'd8, $urandom, makeAddr(r[DMEM_IDX_W-1:0], 2'd0));
        end
    endtask

    // ------------------------------
    // Drive and check
    // ------------------------------

    task automatic driveRow(input int k);
        {regWriteIn, memToRegIn, memReadIn, memWriteIn} = rowCtl[k];
        memFunc = rowFunc[k];
        rAddrIn = rowRAddr[k];
        rtData  = rowRt[k];
        aluData = rowAlu[k];
    endtask

    task automatic checkRow(input int k);
        int t;
        t = rowTest[k];
        testRows[t] = testRows[t] + 1;
        assert (wbRegWrite === rowCtl[k][3])
        else
        begin
            $display("mismatch wbRegWrite test=%s row=%0d exp=%h got=%h",
                     testName[t], k, rowCtl[k][3], wbRegWrite);
            testErr[t] = testErr[t] + 1;
        end
        // Destination and value only mean something on a register write
        if (rowCtl[k][3])
        begin
            assert (wbRAddr === rowRAddr[k])
            else
            begin
                $display("mismatch wbRAddr test=%s row=%0d exp=%h got=%h",
                         testName[t], k, rowRAddr[k], wbRAddr);
                testErr[t] = testErr[t] + 1;
            end
            assert (wbData === rowExp[k])
            else
            begin
                $display("mismatch wbData test=%s row=%0d exp=%08h got=%08h",
                         testName[t], k, rowExp[k], wbData);
                testErr[t] = testErr[t] + 1;
            end
        end
        if (k == rowCtl.size() - 1 || rowTest[k + 1] != t)
            $display("test %s rows=%0d errors=%0d", testName[t], testRows[t], testErr[t]);
    endtask

    initial
    begin
        int totalErr;
        arstN      = 1'b0;
        regWriteIn = 1'b0;
        memToRegIn = 1'b0;
        memReadIn  = 1'b0;
        memWriteIn = 1'b0;
        rAddrIn    = '0;
        memFunc    = MF_WD;
        rtData     = '0;
        aluData    = '0;
        void'($urandom(SEED));
        buildTable();
        tableReady = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        assert (wbRegWrite === 1'b0)
        else
        begin
            $display("mismatch wbRegWrite during reset exp=0 got=%h", wbRegWrite);
            testErr[0] = testErr[0] + 1;
        end
        arstN = 1'b1;
        // Row k goes in at loop step k and comes out at step k + 2
        for (int i = 0; i < rowCtl.size() + 2; i++)
        begin
            @(posedge clk);
            #1;
            if (i >= 2)
                checkRow(i - 2);
            if (i < rowCtl.size())
                driveRow(i);
            else
                {regWriteIn, memToRegIn, memReadIn, memWriteIn} = CTL_IDLE;
        end
        totalErr = 0;
        foreach (testErr[t])
            totalErr += testErr[t];
        $display("tests=%0d rows=%0d errors=%0d", testName.size(), rowCtl.size(), totalErr);
        if (totalErr == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    // Limit scales with the table, margin covers reset and the drain
    initial
    begin
        wait (tableReady);
        #((rowCtl.size() + 20) * CLK_PERIOD);
        $display("Timeout: the row sequence did not complete in time");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/pipeDefsPkg.sv
hw/memOpPkg.sv
hw/exMemReg.sv
hw/memStage.sv
hw/dataMem.sv
hw/memWbReg.sv
hw/memSubsys.sv
tests/memSubsysTb.sv

//--- Makefile
# Verilator build for the memory section testbench

VERILATOR ?= verilator
TOP       ?= memSubsysTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Regression failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
